// ==== memc_settings.svh ====
// ##########################################################
// segment memory controller settings
// sizes shared by the packages, the RTL and the testbench
// ##########################################################

`ifndef MEMC_SETTINGS_SVH
`define MEMC_SETTINGS_SVH

// request channels and RAM banks
`define MEMC_INCNT 4
`define MEMC_RAMCNT 2

// named segments, two of them can run as FIFOs
`define MEMC_SEGCNT 6
`define MEMC_FFCNT 2

// RAM address and data widths
`define MEMC_AW 8
`define MEMC_DW 32

// distance used for almost full and almost empty
`define MEMC_ALM_MARGIN 2

`endif

// ==== memc_ram_pkg.sv ====
// ##########################################################
// memc_ram_pkg
// RAM bank geometry and the widths used on the
// arbiter and FIFO side of the segment memory controller
// ##########################################################

`include "memc_settings.svh"

package memc_ram_pkg;

    // word address and data inside one bank
    localparam int ADR_W = `MEMC_AW;
    localparam int DAT_W = `MEMC_DW;

    // words per bank, one full address space each
    localparam int BANK_DEPTH = 2 ** ADR_W;

    // bank select
    localparam int BANK_W = (`MEMC_RAMCNT > 1) ? $clog2(`MEMC_RAMCNT) : 1;

    // winner index of a bank arbiter
    localparam int CH_W = (`MEMC_INCNT > 1) ? $clog2(`MEMC_INCNT) : 1;

    // FIFO count, one bit more so a full segment fits
    localparam int CNT_W = ADR_W + 1;

endpackage : memc_ram_pkg

// ==== memc_seg_pkg.sv ====
// ##########################################################
// memc_seg_pkg
// constant segment map of both RAM banks and the
// port kind codes seen on the request channels
// ##########################################################

`include "memc_settings.svh"

package memc_seg_pkg;

    import memc_ram_pkg::*;

    localparam int SEGID_W = $clog2(`MEMC_SEGCNT);
    localparam int FFID_W  = (`MEMC_FFCNT > 1) ? $clog2(`MEMC_FFCNT) : 1;
    localparam int PT_W    = 2;

    // port kinds
    localparam logic [PT_W-1:0] PT_RW = 2'd0;
    localparam logic [PT_W-1:0] PT_RO = 2'd1;
    localparam logic [PT_W-1:0] PT_WO = 2'd2;

    // bank 0 holds segments 0..2, bank 1 holds segments 3..5
    localparam logic [ADR_W-1:0] SEG_BASE [`MEMC_SEGCNT] =
        '{8'd0, 8'd64, 8'd128, 8'd0, 8'd128, 8'd192};
    localparam logic [CNT_W-1:0] SEG_SIZE [`MEMC_SEGCNT] =
        '{9'd64, 9'd64, 9'd16, 9'd128, 9'd8, 9'd64};
    localparam logic [BANK_W-1:0] SEG_BANK [`MEMC_SEGCNT] =
        '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};

    // segments 2 and 4 can be driven by FIFO 0 and FIFO 1
    localparam logic SEG_IS_FIFO [`MEMC_SEGCNT] = '{0, 0, 1, 0, 1, 0};
    localparam logic [FFID_W-1:0] SEG_FIFO_ID [`MEMC_SEGCNT] =
        '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

    // owning segment of each FIFO
    localparam logic [SEGID_W-1:0] FFIDS [`MEMC_FFCNT] = '{3'd2, 3'd4};

endpackage : memc_seg_pkg

// ==== memc_seg_fifo.sv ====
// ##########################################################
// memc_seg_fifo
// pointer FIFO over one segment region, keeps the read
// and write pointers plus the occupancy count, and derives
// full, almost full, empty and almost empty from the count
// ##########################################################

`include "memc_settings.svh"

module memc_seg_fifo import memc_ram_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             en_i,
    input  logic             clr_i,
    input  logic             wr_i,
    input  logic             rd_i,
    output logic [ADR_W-1:0] wr_ptr_o,
    output logic [ADR_W-1:0] rd_ptr_o,
    output logic [CNT_W-1:0] cnt_o,
    output logic             full_o,
    output logic             almf_o,
    output logic             empt_o,
    output logic             alme_o
);

    logic do_wr;
    logic do_rd;

    // pointers wrap at the segment size, not at the address width
    function automatic logic [ADR_W-1:0] ptr_inc(input logic [ADR_W-1:0] ptr);
        logic [ADR_W-1:0] nxt;
        nxt = (ptr == ADR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    // wr_i and rd_i come from granted accesses only
    assign do_wr = en_i & wr_i & ~full_o;
    assign do_rd = en_i & rd_i & ~empt_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_o <= '0;
            rd_ptr_o <= '0;
            cnt_o    <= '0;
        end else if (clr_i) begin
            wr_ptr_o <= '0;
            rd_ptr_o <= '0;
            cnt_o    <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_o <= ptr_inc(wr_ptr_o);
            end
            if (do_rd) begin
                rd_ptr_o <= ptr_inc(rd_ptr_o);
            end
            // read and write together keep the count
            case ({do_wr, do_rd})
                2'b10:   cnt_o <= cnt_o + 1'b1;
                2'b01:   cnt_o <= cnt_o - 1'b1;
                default: cnt_o <= cnt_o;
            endcase
        end
    end

    assign full_o = (cnt_o == CNT_W'(DEPTH));
    assign empt_o = (cnt_o == '0);
    assign almf_o = (cnt_o >= CNT_W'(DEPTH - `MEMC_ALM_MARGIN));
    assign alme_o = (cnt_o <= CNT_W'(`MEMC_ALM_MARGIN));

endmodule : memc_seg_fifo

// ==== memc_rr_arb.sv ====
// ##########################################################
// memc_rr_arb
// round-robin arbiter for one RAM bank, grants a single
// requester per cycle, searching upward from a rotating
// priority pointer that moves past each winner
// ##########################################################

module memc_rr_arb #(
    parameter  int NUM_IN = 4,
    localparam int IW     = (NUM_IN > 1) ? $clog2(NUM_IN) : 1
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic [NUM_IN-1:0] req_i,
    output logic [NUM_IN-1:0] gnt_o,
    output logic [IW-1:0]     idx_o
);

    localparam int SW = IW + 1;

    logic [IW-1:0] ptr_q;
    logic [SW-1:0] cand_sum;
    logic [IW-1:0] cand;
    logic          found;

    // combinational search, the grant lands in the request cycle
    always_comb begin
        found    = 1'b0;
        idx_o    = '0;
        cand_sum = '0;
        cand     = '0;
        for (int i = 0; i < NUM_IN; i++) begin
            cand_sum = {1'b0, ptr_q} + SW'(i);
            // wrap around the top of the request vector
            if (cand_sum >= SW'(NUM_IN)) begin
                cand = IW'(cand_sum - SW'(NUM_IN));
            end else begin
                cand = IW'(cand_sum);
            end
            if (!found && req_i[cand]) begin
                found = 1'b1;
                idx_o = cand;
            end
        end
        gnt_o = '0;
        if (found) begin
            gnt_o[idx_o] = 1'b1;
        end
    end

    // pointer only moves when a grant was given
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q <= '0;
        end else if (found) begin
            ptr_q <= (idx_o == IW'(NUM_IN - 1)) ? '0 : idx_o + 1'b1;
        end
    end

endmodule : memc_rr_arb

// ==== sce_memc.sv ====
// ##########################################################
// sce_memc
// segment memory controller, decodes each channel's
// segment to bank and base, gates FIFO segments on their
// status, arbitrates each bank round-robin and returns
// read data one cycle after the ready cycle
// ##########################################################

`include "memc_settings.svh"

module sce_memc import memc_ram_pkg::*, memc_seg_pkg::*; (
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    // channel side
    input  logic [`MEMC_INCNT-1:0][SEGID_W-1:0]  seg_id_i,
    input  logic [`MEMC_INCNT-1:0][ADR_W-1:0]    seg_ptr_i,
    input  logic [`MEMC_INCNT-1:0]               seg_rd_i,
    input  logic [`MEMC_INCNT-1:0]               seg_wr_i,
    input  logic [`MEMC_INCNT-1:0][DAT_W-1:0]    seg_wdat_i,
    input  logic [`MEMC_INCNT-1:0][PT_W-1:0]     port_kind_i,
    output logic [`MEMC_INCNT-1:0]               seg_ready_o,
    output logic [`MEMC_INCNT-1:0][DAT_W-1:0]    seg_rdat_o,
    // bank side
    output logic [`MEMC_RAMCNT-1:0][ADR_W-1:0]   ram_addr_o,
    output logic [`MEMC_RAMCNT-1:0]              ram_rd_o,
    output logic [`MEMC_RAMCNT-1:0]              ram_wr_o,
    output logic [`MEMC_RAMCNT-1:0][DAT_W-1:0]   ram_wdat_o,
    input  logic [`MEMC_RAMCNT-1:0][DAT_W-1:0]   ram_rdat_i,
    // FIFO control and status
    input  logic [`MEMC_FFCNT-1:0]               fifo_en_i,
    input  logic [`MEMC_FFCNT-1:0]               fifo_clr_i,
    output logic [`MEMC_FFCNT-1:0][CNT_W-1:0]    fifo_cnt_o,
    output logic [`MEMC_FFCNT-1:0][3:0]          fifo_sr_o
);

    logic [`MEMC_INCNT-1:0][BANK_W-1:0]  ch_bank;
    logic [`MEMC_INCNT-1:0][BANK_W-1:0]  ch_bank_q;
    logic [`MEMC_INCNT-1:0][ADR_W-1:0]   ch_addr;
    logic [`MEMC_INCNT-1:0]              ch_rd;
    logic [`MEMC_INCNT-1:0]              ch_wr;
    logic [`MEMC_INCNT-1:0]              ch_req;
    logic [`MEMC_RAMCNT-1:0][`MEMC_INCNT-1:0] bank_req;
    logic [`MEMC_RAMCNT-1:0][`MEMC_INCNT-1:0] bank_gnt;
    logic [`MEMC_RAMCNT-1:0][CH_W-1:0]   bank_idx;
    logic [`MEMC_FFCNT-1:0]              ff_wr, ff_rd;
    logic [`MEMC_FFCNT-1:0]              ff_full, ff_almf, ff_empt, ff_alme;
    logic [`MEMC_FFCNT-1:0][ADR_W-1:0]   ff_wr_ptr, ff_rd_ptr;

    for (genvar c = 0; c < `MEMC_INCNT; c++) begin : g_ch
        logic [SEGID_W-1:0] sid;
        logic [FFID_W-1:0]  fid;
        logic               ff_on;
        logic               can_rd, can_wr;
        logic [ADR_W-1:0]   ptr;

        assign sid   = seg_id_i[c];
        assign fid   = SEG_FIFO_ID[sid];
        assign ff_on = SEG_IS_FIFO[sid] & fifo_en_i[fid];
        assign ch_bank[c] = SEG_BANK[sid];

        assign can_rd = (port_kind_i[c] == PT_RW) | (port_kind_i[c] == PT_RO);
        assign can_wr = (port_kind_i[c] == PT_RW) | (port_kind_i[c] == PT_WO);

        // one operation per request, a read wins over a write
        assign ch_rd[c] = seg_rd_i[c] & can_rd & ~(ff_on & ff_empt[fid]);
        assign ch_wr[c] = seg_wr_i[c] & ~seg_rd_i[c] & can_wr & ~(ff_on & ff_full[fid]);
        assign ch_req[c] = ch_rd[c] | ch_wr[c];

        // an enabled FIFO supplies the pointer
        assign ptr = ~ff_on       ? seg_ptr_i[c] :
                     seg_rd_i[c]  ? ff_rd_ptr[fid] : ff_wr_ptr[fid];
        assign ch_addr[c] = SEG_BASE[sid] + ptr;

        // bank of the last cycle picks the returning read word
        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                ch_bank_q[c] <= '0;
            end else begin
                ch_bank_q[c] <= ch_bank[c];
            end
        end
        assign seg_rdat_o[c] = ram_rdat_i[ch_bank_q[c]];
    end

    for (genvar b = 0; b < `MEMC_RAMCNT; b++) begin : g_bank
        logic any_gnt;

        for (genvar c = 0; c < `MEMC_INCNT; c++) begin : g_req
            assign bank_req[b][c] = ch_req[c] & (ch_bank[c] == BANK_W'(b));
        end

        memc_rr_arb #(
            .NUM_IN (`MEMC_INCNT)
        ) u_arb (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .req_i    (bank_req[b]),
            .gnt_o    (bank_gnt[b]),
            .idx_o    (bank_idx[b])
        );

        // winner's request goes onto the bank
        assign any_gnt       = |bank_gnt[b];
        assign ram_addr_o[b] = ch_addr[bank_idx[b]];
        assign ram_rd_o[b]   = any_gnt & ch_rd[bank_idx[b]];
        assign ram_wr_o[b]   = any_gnt & ch_wr[bank_idx[b]];
        assign ram_wdat_o[b] = seg_wdat_i[bank_idx[b]];
    end

    // a channel only requests its own bank, so the grants just merge
    always_comb begin
        seg_ready_o = '0;
        for (int b = 0; b < `MEMC_RAMCNT; b++) begin
            seg_ready_o |= bank_gnt[b];
        end
    end

    for (genvar k = 0; k < `MEMC_FFCNT; k++) begin : g_ff
        localparam int SID = FFIDS[k];
        localparam int BK  = SEG_BANK[SID];
        logic hit;

        // granted operation on this bank targets the FIFO segment
        assign hit      = (seg_id_i[bank_idx[BK]] == SEGID_W'(SID));
        assign ff_wr[k] = ram_wr_o[BK] & hit;
        assign ff_rd[k] = ram_rd_o[BK] & hit;

        memc_seg_fifo #(
            .DEPTH (int'(SEG_SIZE[SID]))
        ) u_fifo (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .en_i     (fifo_en_i[k]),
            .clr_i    (fifo_clr_i[k]),
            .wr_i     (ff_wr[k]),
            .rd_i     (ff_rd[k]),
            .wr_ptr_o (ff_wr_ptr[k]),
            .rd_ptr_o (ff_rd_ptr[k]),
            .cnt_o    (fifo_cnt_o[k]),
            .full_o   (ff_full[k]),
            .almf_o   (ff_almf[k]),
            .empt_o   (ff_empt[k]),
            .alme_o   (ff_alme[k])
        );

        assign fifo_sr_o[k] = {ff_full[k], ff_almf[k], ff_empt[k], ff_alme[k]};
    end

endmodule : sce_memc

// ==== memc_sram.sv ====
// ##########################################################
// memc_sram
// behavioral single-port RAM bank, synchronous write and
// a registered read with one cycle of latency
// ##########################################################

module memc_sram import memc_ram_pkg::*; #(
    parameter int DEPTH = 256
) (
    input  logic             clk,
    input  logic             rd_i,
    input  logic             wr_i,
    input  logic [ADR_W-1:0] addr_i,
    input  logic [DAT_W-1:0] wdat_i,
    output logic [DAT_W-1:0] rdat_o
);

    logic [DAT_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[addr_i] <= wdat_i;
        end
        // read port holds its word between reads
        if (rd_i) begin
            rdat_o <= mem[addr_i];
        end
    end

endmodule : memc_sram

// ==== sce_memc_top.sv ====
// ##########################################################
// sce_memc_top
// segment memory controller with its RAM banks
// ##########################################################

`include "memc_settings.svh"

module sce_memc_top import memc_ram_pkg::*, memc_seg_pkg::*; (
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    input  logic [`MEMC_INCNT-1:0][SEGID_W-1:0]  seg_id_i,
    input  logic [`MEMC_INCNT-1:0][ADR_W-1:0]    seg_ptr_i,
    input  logic [`MEMC_INCNT-1:0]               seg_rd_i,
    input  logic [`MEMC_INCNT-1:0]               seg_wr_i,
    input  logic [`MEMC_INCNT-1:0][DAT_W-1:0]    seg_wdat_i,
    input  logic [`MEMC_INCNT-1:0][PT_W-1:0]     port_kind_i,
    output logic [`MEMC_INCNT-1:0]               seg_ready_o,
    output logic [`MEMC_INCNT-1:0][DAT_W-1:0]    seg_rdat_o,
    input  logic [`MEMC_FFCNT-1:0]               fifo_en_i,
    input  logic [`MEMC_FFCNT-1:0]               fifo_clr_i,
    output logic [`MEMC_FFCNT-1:0][CNT_W-1:0]    fifo_cnt_o,
    output logic [`MEMC_FFCNT-1:0][3:0]          fifo_sr_o
);

    logic [`MEMC_RAMCNT-1:0][ADR_W-1:0] ram_addr;
    logic [`MEMC_RAMCNT-1:0]            ram_rd;
    logic [`MEMC_RAMCNT-1:0]            ram_wr;
    logic [`MEMC_RAMCNT-1:0][DAT_W-1:0] ram_wdat;
    logic [`MEMC_RAMCNT-1:0][DAT_W-1:0] ram_rdat;

    sce_memc u_memc (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .seg_id_i    (seg_id_i),
        .seg_ptr_i   (seg_ptr_i),
        .seg_rd_i    (seg_rd_i),
        .seg_wr_i    (seg_wr_i),
        .seg_wdat_i  (seg_wdat_i),
        .port_kind_i (port_kind_i),
        .seg_ready_o (seg_ready_o),
        .seg_rdat_o  (seg_rdat_o),
        .ram_addr_o  (ram_addr),
        .ram_rd_o    (ram_rd),
        .ram_wr_o    (ram_wr),
        .ram_wdat_o  (ram_wdat),
        .ram_rdat_i  (ram_rdat),
        .fifo_en_i   (fifo_en_i),
        .fifo_clr_i  (fifo_clr_i),
        .fifo_cnt_o  (fifo_cnt_o),
        .fifo_sr_o   (fifo_sr_o)
    );

    for (genvar b = 0; b < `MEMC_RAMCNT; b++) begin : g_ram
        memc_sram #(
            .DEPTH (BANK_DEPTH)
        ) u_sram (
            .clk    (clk),
            .rd_i   (ram_rd[b]),
            .wr_i   (ram_wr[b]),
            .addr_i (ram_addr[b]),
            .wdat_i (ram_wdat[b]),
            .rdat_o (ram_rdat[b])
        );
    end

endmodule : sce_memc_top

// ==== tb_sce_memc_sva.sv ====
// ##########################################################
// tb_sce_memc_sva
// grant and FIFO invariants of the segment memory controller
// ##########################################################

`include "memc_settings.svh"

module tb_sce_memc_sva (
    input logic                                       clk,
    input logic                                       arst_n_i,
    input logic [`MEMC_RAMCNT-1:0][`MEMC_INCNT-1:0]   bank_gnt,
    input logic [`MEMC_RAMCNT-1:0]                    ram_rd_o,
    input logic [`MEMC_RAMCNT-1:0]                    ram_wr_o,
    input logic [`MEMC_FFCNT-1:0]                     fifo_en_i,
    input logic [`MEMC_FFCNT-1:0]                     ff_full,
    input logic [`MEMC_FFCNT-1:0]                     ff_empt,
    input logic [`MEMC_FFCNT-1:0]                     ff_wr
);

    timeunit 1ns;
    timeprecision 1ps;

    // number of failed assertions
    int fail_cnt = 0;

    for (genvar b = 0; b < `MEMC_RAMCNT; b++) begin : g_bank
        a_gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
            $onehot0(bank_gnt[b])) else begin
            fail_cnt++;
            $error("bank %0d grant not one-hot", b);
        end
        a_no_rd_wr: assert property (@(posedge clk) disable iff (!arst_n_i)
            !(ram_rd_o[b] && ram_wr_o[b])) else begin
            fail_cnt++;
            $error("bank %0d read and write", b);
        end
    end

    for (genvar k = 0; k < `MEMC_FFCNT; k++) begin : g_ff
        a_full_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
            !(ff_full[k] && ff_empt[k])) else begin
            fail_cnt++;
            $error("FIFO %0d full and empty", k);
        end
        a_wr_full: assert property (@(posedge clk) disable iff (!arst_n_i)
            !(fifo_en_i[k] && ff_wr[k] && ff_full[k])) else begin
            fail_cnt++;
            $error("FIFO %0d written full", k);
        end
    end

endmodule : tb_sce_memc_sva

bind sce_memc tb_sce_memc_sva u_sva (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .bank_gnt  (bank_gnt),
    .ram_rd_o  (ram_rd_o),
    .ram_wr_o  (ram_wr_o),
    .fifo_en_i (fifo_en_i),
    .ff_full   (ff_full),
    .ff_empt   (ff_empt),
    .ff_wr     (ff_wr)
);

// ==== tb_sce_memc.sv ====
// ##########################################################
// tb_sce_memc
// testbench for the segment memory controller that drives
// the request channels and checks ready, bank address, read
// data and FIFO status against a reference model
// ##########################################################

`include "memc_settings.svh"

module tb_sce_memc import memc_ram_pkg::*, memc_seg_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NRAND = 120;
    localparam int TEST_CYCLES = 8 + NRAND * 8 + 400;

    logic clk;
    logic arst_n;
    logic [`MEMC_INCNT-1:0][SEGID_W-1:0] seg_id;
    logic [`MEMC_INCNT-1:0][ADR_W-1:0]   seg_ptr;
    logic [`MEMC_INCNT-1:0]              seg_rd;
    logic [`MEMC_INCNT-1:0]              seg_wr;
    logic [`MEMC_INCNT-1:0][DAT_W-1:0]   seg_wdat;
    logic [`MEMC_INCNT-1:0][PT_W-1:0]    port_kind;
    logic [`MEMC_INCNT-1:0]              seg_ready;
    logic [`MEMC_INCNT-1:0][DAT_W-1:0]   seg_rdat;
    logic [`MEMC_FFCNT-1:0]              fifo_en;
    logic [`MEMC_FFCNT-1:0]              fifo_clr;
    logic [`MEMC_FFCNT-1:0][CNT_W-1:0]   fifo_cnt;
    logic [`MEMC_FFCNT-1:0][3:0]         fifo_sr;

    // reference model state
    logic [DAT_W-1:0] shadow [`MEMC_RAMCNT][BANK_DEPTH];
    bit               written [`MEMC_RAMCNT][BANK_DEPTH];
    logic [DAT_W-1:0] ffq [`MEMC_FFCNT][$];
    int               arb_ptr [`MEMC_RAMCNT];
    int               m_cnt [`MEMC_FFCNT];
    int               m_wp [`MEMC_FFCNT];
    int               m_rp [`MEMC_FFCNT];
    bit               rd_pend [`MEMC_INCNT];
    logic [DAT_W-1:0] rd_exp [`MEMC_INCNT];
    int               wait_cnt [`MEMC_INCNT];

    sce_memc_top dut0 (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .seg_id_i    (seg_id),
        .seg_ptr_i   (seg_ptr),
        .seg_rd_i    (seg_rd),
        .seg_wr_i    (seg_wr),
        .seg_wdat_i  (seg_wdat),
        .port_kind_i (port_kind),
        .seg_ready_o (seg_ready),
        .seg_rdat_o  (seg_rdat),
        .fifo_en_i   (fifo_en),
        .fifo_clr_i  (fifo_clr),
        .fifo_cnt_o  (fifo_cnt),
        .fifo_sr_o   (fifo_sr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    function automatic bit fifo_on(input int c);
        int sid;
        sid = seg_id[c];
        return SEG_IS_FIFO[sid] && fifo_en[SEG_FIFO_ID[sid]];
    endfunction

    function automatic bit chan_rd(input int c);
        int k;
        k = SEG_FIFO_ID[seg_id[c]];
        return seg_rd[c] && port_kind[c] != PT_WO && !(fifo_on(c) && m_cnt[k] == 0);
    endfunction

    function automatic bit chan_wr(input int c);
        int sid;
        int k;
        sid = seg_id[c];
        k = SEG_FIFO_ID[sid];
        return seg_wr[c] && !seg_rd[c] && port_kind[c] != PT_RO
            && !(fifo_on(c) && m_cnt[k] == int'(SEG_SIZE[sid]));
    endfunction

    function automatic logic [ADR_W-1:0] chan_addr(input int c);
        int sid;
        int ptr;
        sid = seg_id[c];
        ptr = seg_ptr[c];
        if (fifo_on(c)) begin
            ptr = seg_rd[c] ? m_rp[SEG_FIFO_ID[sid]] : m_wp[SEG_FIFO_ID[sid]];
        end
        return ADR_W'(int'(SEG_BASE[sid]) + ptr);
    endfunction

    // expected ready vector by rotating search from each bank pointer
    function automatic logic [`MEMC_INCNT-1:0] ref_ready();
        logic [`MEMC_INCNT-1:0] rdy;
        bit found;
        int p;
        rdy = '0;
        for (int b = 0; b < `MEMC_RAMCNT; b++) begin
            found = 0;
            for (int i = 0; i < `MEMC_INCNT; i++) begin
                p = (arb_ptr[b] + i) % `MEMC_INCNT;
                if (!found && (chan_rd(p) || chan_wr(p)) && SEG_BANK[seg_id[p]] == b) begin
                    found = 1;
                    rdy[p] = 1'b1;
                end
            end
        end
        return rdy;
    endfunction

    always @(posedge clk) begin : compare
        logic [`MEMC_INCNT-1:0] exp_rdy;
        logic [ADR_W-1:0] a [`MEMC_INCNT];
        bit r [`MEMC_INCNT];
        bit w [`MEMC_INCNT];
        int b;
        int k;
        int sz;
        if (arst_n) begin
            for (int c = 0; c < `MEMC_INCNT; c++) begin
                if (rd_pend[c]) begin
                    check($sformatf("seg_rdat_o[%0d]", c), seg_rdat[c], rd_exp[c]);
                end
                rd_pend[c] = 0;
            end
            for (int f = 0; f < `MEMC_FFCNT; f++) begin
                sz = SEG_SIZE[FFIDS[f]];
                check($sformatf("fifo_cnt_o[%0d]", f), fifo_cnt[f], m_cnt[f]);
                check($sformatf("fifo_sr_o[%0d]", f), fifo_sr[f],
                      {m_cnt[f] == sz, m_cnt[f] >= sz - `MEMC_ALM_MARGIN,
                       m_cnt[f] == 0, m_cnt[f] <= `MEMC_ALM_MARGIN});
            end
            exp_rdy = ref_ready();
            check("seg_ready_o", seg_ready, exp_rdy);
            for (int c = 0; c < `MEMC_INCNT; c++) begin
                a[c] = chan_addr(c);
                r[c] = chan_rd(c);
                w[c] = chan_wr(c);
                if ((r[c] || w[c]) && !seg_ready[c]) begin
                    wait_cnt[c]++;
                    if (wait_cnt[c] >= `MEMC_INCNT) begin
                        $display("channel %0d was not served within %0d cycles", c, `MEMC_INCNT);
                        $display("TEST FAILED");
                        $fatal(1);
                    end
                end else begin
                    wait_cnt[c] = 0;
                end
            end
            for (int c = 0; c < `MEMC_INCNT; c++) begin
                if (exp_rdy[c]) begin
                    b = SEG_BANK[seg_id[c]];
                    k = SEG_FIFO_ID[seg_id[c]];
                    sz = SEG_SIZE[seg_id[c]];
                    check($sformatf("ram_addr[%0d]", b), dut0.ram_addr[b], a[c]);
                    arb_ptr[b] = (c + 1) % `MEMC_INCNT;
                    if (r[c] && fifo_on(c)) begin
                        rd_exp[c] = ffq[k].pop_front();
                        rd_pend[c] = 1;
                        m_rp[k] = (m_rp[k] + 1) % sz;
                        m_cnt[k]--;
                    end else if (r[c]) begin
                        rd_exp[c] = shadow[b][a[c]];
                        rd_pend[c] = written[b][a[c]];
                    end else begin
                        shadow[b][a[c]] = seg_wdat[c];
                        written[b][a[c]] = 1;
                        if (fifo_on(c)) begin
                            ffq[k].push_back(seg_wdat[c]);
                            m_wp[k] = (m_wp[k] + 1) % sz;
                            m_cnt[k]++;
                        end
                    end
                end
            end
            // clear beats any access at the same edge
            for (int f = 0; f < `MEMC_FFCNT; f++) begin
                if (fifo_clr[f]) begin
                    m_cnt[f] = 0;
                    m_wp[f] = 0;
                    m_rp[f] = 0;
                    ffq[f].delete();
                end
            end
        end
    end

    // starts on a falling edge and returns on the falling edge after the grant
    task automatic issue(input int c, input int sid, input int ptr, input bit rd,
                         input logic [PT_W-1:0] kind, input logic [DAT_W-1:0] d);
        seg_id[c] = SEGID_W'(sid);
        seg_ptr[c] = ADR_W'(ptr);
        seg_rd[c] = rd;
        seg_wr[c] = !rd;
        port_kind[c] = kind;
        seg_wdat[c] = d;
        do @(posedge clk); while (!seg_ready[c]);
        @(negedge clk);
        seg_rd[c] = 1'b0;
        seg_wr[c] = 1'b0;
    endtask

    // request that must stay unanswered for n cycles before it is dropped
    task automatic hold_blocked(input int c, input int sid, input bit rd,
                                input logic [PT_W-1:0] kind, input int n);
        seg_id[c] = SEGID_W'(sid);
        seg_ptr[c] = '0;
        seg_rd[c] = rd;
        seg_wr[c] = !rd;
        port_kind[c] = kind;
        seg_wdat[c] = $urandom;
        repeat (n) @(posedge clk);
        @(negedge clk);
        seg_rd[c] = 1'b0;
        seg_wr[c] = 1'b0;
    endtask

    task automatic rand_chan(input int c, input int n);
        int sid;
        bit op;
        logic [PT_W-1:0] kind;
        @(negedge clk);
        repeat (n) begin
            sid = $urandom % `MEMC_SEGCNT;
            op = $urandom % 2;
            kind = ($urandom % 2) ? (op ? PT_RO : PT_WO) : PT_RW;
            issue(c, sid, $urandom % int'(SEG_SIZE[sid]), op, kind, $urandom);
        end
    endtask

    task automatic fifo_run(input int c, input int k);
        int sid;
        int sz;
        sid = FFIDS[k];
        sz = SEG_SIZE[sid];
        @(negedge clk);
        fifo_en[k] = 1'b1;
        repeat (sz) issue(c, sid, 0, 0, PT_RW, $urandom);
        hold_blocked(c, sid, 0, PT_RW, 5);
        repeat (sz) issue(c, sid, 0, 1, PT_RW, '0);
        hold_blocked(c, sid, 1, PT_RW, 5);
        repeat (3) issue(c, sid, 0, 0, PT_RW, $urandom);
        fifo_clr[k] = 1'b1;
        @(negedge clk);
        fifo_clr[k] = 1'b0;
        hold_blocked(c, sid, 1, PT_RW, 3);
        // disabled FIFO falls back to direct addressing
        fifo_en[k] = 1'b0;
        issue(c, sid, 5, 0, PT_RW, $urandom);
        issue(c, sid, 5, 1, PT_RW, '0);
    endtask

    initial begin : watchdog
        #(TEST_CYCLES * 20);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'hfd7ae2b9));
        arst_n = 1'b0;
        seg_id = '0;
        seg_ptr = '0;
        seg_rd = '0;
        seg_wr = '0;
        seg_wdat = '0;
        port_kind = '0;
        fifo_en = '0;
        fifo_clr = '0;
        foreach (arb_ptr[b]) arb_ptr[b] = 0;
        foreach (m_cnt[f]) begin
            m_cnt[f] = 0;
            m_wp[f] = 0;
            m_rp[f] = 0;
        end
        foreach (rd_pend[c]) begin
            rd_pend[c] = 0;
            wait_cnt[c] = 0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        fork
            rand_chan(0, NRAND);
            rand_chan(1, NRAND);
            rand_chan(2, NRAND);
            rand_chan(3, NRAND);
        join
        fork
            fifo_run(0, 0);
            fifo_run(2, 1);
            begin
                @(negedge clk);
                hold_blocked(1, 0, 0, PT_RO, 5);
            end
            begin
                @(negedge clk);
                hold_blocked(3, 5, 1, PT_WO, 5);
            end
        join
        repeat (5) @(negedge clk);
        if (dut0.u_memc.u_sva.fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_sce_memc

// ==== verilog.f ====
+incdir+.
memc_ram_pkg.sv
memc_seg_pkg.sv
memc_seg_fifo.sv
memc_rr_arb.sv
sce_memc.sv
memc_sram.sv
sce_memc_top.sv
tb_sce_memc_sva.sv
tb_sce_memc.sv

// ==== Makefile ====
# Verilator build and run for the segment memory controller

VERILATOR ?= verilator
TOP       ?= tb_sce_memc
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
